/* Bender.yml */
package:
  name: cd_rx

sources:
  - hw/cd_frame_pkg.sv
  - hw/cd_phy_pkg.sv
  - hw/rx_bit_timer.sv
  - hw/rx_ser.sv
  - hw/rx_bytes.sv
  - hw/rx_pp_ram.sv
  - hw/cd_rx_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_cd_rx.sv

/* hw/cd_frame_pkg.sv */
// frame-level types for the receive path
// address, length, flags and byte counter widths
// broadcast address and frame overhead constants
// write port bundle from the frame FSM to the page buffer

package cd_frame_pkg;

    typedef logic [7:0] addr_t;      // node address
    typedef logic [7:0] len_t;       // data length field
    typedef logic [7:0] flags_t;     // 0: good frame, else rx byte count
    typedef logic [7:0] buf_addr_t;  // byte offset within a page
    typedef logic [8:0] byte_cnt_t;  // extra bit shows overflow past 255

    // matches any node
    localparam addr_t BROADCAST_ADDR = 8'hff;

    // src, dst, len, crc_l, crc_h
    localparam int FRAME_OVERHEAD = 5;

    typedef struct packed {
        logic [7:0] wr_byte;  // byte from the deserializer
        buf_addr_t  wr_addr;
        logic       wr_clk;   // one-cycle write strobe
    } wr_port_t;

endpackage

/* hw/cd_phy_pkg.sv */
// serial-side types for the receive path
// bit divider and crc widths
// idle rule and crc-16 constants
// byte strobe bundle from the deserializer

package cd_phy_pkg;

    typedef logic [15:0] div_t;  // clocks per bit
    typedef logic [15:0] crc_t;  // crc-16 value

    // high bit times before the line counts as idle
    localparam int IDLE_BITS = 10;

    localparam crc_t CRC_INIT = 16'hffff;
    localparam crc_t CRC_POLY = 16'ha001;  // modbus, reflected

    typedef struct packed {
        logic [7:0] data;
        crc_t       crc;     // running crc, includes data
        logic       strobe;  // one cycle per byte
    } ser_byte_t;

endpackage

/* hw/cd_rx_top.sv */
// receive path top level
// bit timer, deserializer, frame FSM and ping-pong buffer

`timescale 1ns/1ns

module cd_rx_top (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    rx,
    input  cd_phy_pkg::div_t        baud_div,
    input  cd_frame_pkg::addr_t     filter,
    input  logic                    user_crc,
    input  logic                    not_drop,
    input  logic                    abort,
    output logic                    error,
    input  cd_frame_pkg::buf_addr_t rd_addr,
    input  logic                    rd_done,
    output logic [7:0]              rd_byte,
    output cd_frame_pkg::flags_t    rd_flags,
    output logic                    rd_ready,
    output logic                    rx_lost
);
    import cd_phy_pkg::*;
    import cd_frame_pkg::*;

    logic      sample_tick;
    logic      hunt;
    logic      bus_idle;
    logic      force_wait_idle;
    ser_byte_t ser;
    wr_port_t  wr;
    flags_t    wr_flags;
    logic      switch;

    rx_bit_timer u_rx_bit_timer (
        .clk         (clk),
        .reset_n     (reset_n),
        .rx          (rx),
        .hunt        (hunt),
        .baud_div    (baud_div),
        .sample_tick (sample_tick),
        .bus_idle    (bus_idle)
    );

    rx_ser u_rx_ser (
        .clk             (clk),
        .reset_n         (reset_n),
        .rx              (rx),
        .sample_tick     (sample_tick),
        .force_wait_idle (force_wait_idle),
        .bus_idle        (bus_idle),
        .hunt            (hunt),
        .ser             (ser)
    );

    rx_bytes u_rx_bytes (
        .clk             (clk),
        .reset_n         (reset_n),
        .filter          (filter),
        .user_crc        (user_crc),
        .not_drop        (not_drop),
        .abort           (abort),
        .error           (error),
        .bus_idle        (bus_idle),
        .ser             (ser),
        .force_wait_idle (force_wait_idle),
        .wr              (wr),
        .wr_flags        (wr_flags),
        .switch          (switch)
    );

    rx_pp_ram u_rx_pp_ram (
        .clk      (clk),
        .reset_n  (reset_n),
        .wr       (wr),
        .wr_flags (wr_flags),
        .switch   (switch),
        .rd_addr  (rd_addr),
        .rd_done  (rd_done),
        .rd_byte  (rd_byte),
        .rd_flags (rd_flags),
        .rd_ready (rd_ready),
        .rx_lost  (rx_lost)
    );

endmodule

/* hw/rx_bit_timer.sv */
// bit timer for the serial receiver
// baud divider with phase restart on a start edge
// mid-bit sample tick and idle-line detection

`timescale 1ns/1ns

module rx_bit_timer (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             rx,
    input  logic             hunt,
    input  cd_phy_pkg::div_t baud_div,
    output logic             sample_tick,
    output logic             bus_idle
);
    import cd_phy_pkg::*;

    localparam int IDLE_W = $clog2(IDLE_BITS + 1);

    div_t              div_cnt;
    logic              rx_q;
    logic              start_edge;
    logic              bit_end;
    logic [IDLE_W-1:0] idle_cnt;

    assign start_edge  = hunt && rx_q && !rx;
    assign bit_end     = (div_cnt >= baud_div - 1'b1);
    assign sample_tick = !start_edge && (div_cnt == (baud_div >> 1));

    // phase counter within one bit
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rx_q    <= 1'b1;  // line idles high
            div_cnt <= '0;
        end else begin
            rx_q <= rx;
            if (start_edge) begin
                div_cnt <= div_t'(1);  // edge cycle counts as phase 0
            end else if (bit_end) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // whole bit times of a high line while hunting
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idle_cnt <= '0;
            bus_idle <= 1'b0;
        end else if (!rx) begin
            idle_cnt <= '0;
            bus_idle <= 1'b0;
        end else if (hunt) begin
            if (bit_end && idle_cnt != IDLE_W'(IDLE_BITS)) begin
                idle_cnt <= idle_cnt + 1'b1;
            end
            if (idle_cnt == IDLE_W'(IDLE_BITS)) begin
                bus_idle <= 1'b1;
            end
        end else begin
            idle_cnt <= '0;
        end
    end

endmodule

/* hw/rx_bytes.sv */
// receive frame FSM
// address filter, length latch and byte counting
// crc residue check, error pulse and page switch with flags
// frame: src, dst, len, data bytes, crc_l, crc_h

`timescale 1ns/1ns

module rx_bytes (
    input  logic                   clk,
    input  logic                   reset_n,
    input  cd_frame_pkg::addr_t    filter,
    input  logic                   user_crc,
    input  logic                   not_drop,
    input  logic                   abort,
    output logic                   error,
    input  logic                   bus_idle,
    input  cd_phy_pkg::ser_byte_t  ser,
    output logic                   force_wait_idle,
    output cd_frame_pkg::wr_port_t wr,
    output cd_frame_pkg::flags_t   wr_flags,
    output logic                   switch
);
    import cd_frame_pkg::*;

    typedef enum logic [1:0] {
        INIT = 2'b01,
        DATA = 2'b10
    } state_t;

    state_t    state;
    byte_cnt_t byte_cnt;
    byte_cnt_t last_idx;   // offset of crc_h
    len_t      data_len;
    logic      drop_flag;  // frame not for this node
    buf_addr_t wr_addr_q;
    logic      wr_clk_q;

    function automatic flags_t sat_count(byte_cnt_t cnt);
        return cnt[8] ? flags_t'(8'hff) : cnt[7:0];
    endfunction

    assign last_idx = byte_cnt_t'(data_len) + byte_cnt_t'(FRAME_OVERHEAD - 1);
    assign wr       = '{wr_byte: ser.data, wr_addr: wr_addr_q, wr_clk: wr_clk_q};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state           <= INIT;
            force_wait_idle <= 1'b0;
        end else begin
            force_wait_idle <= 1'b0;
            case (state)
                INIT: begin
                    force_wait_idle <= !bus_idle;  // resync on the next idle gap
                    state           <= DATA;
                end
                DATA: begin
                    if (switch || error) begin
                        state <= INIT;
                    end
                end
                default: state <= INIT;
            endcase
            if (abort) begin
                state <= INIT;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            error     <= 1'b0;
            switch    <= 1'b0;
            wr_flags  <= '0;
            wr_addr_q <= '0;
            wr_clk_q  <= 1'b0;
            byte_cnt  <= '0;
            data_len  <= '0;
            drop_flag <= 1'b0;
        end else begin
            error    <= 1'b0;
            switch   <= 1'b0;
            wr_clk_q <= 1'b0;
            if (state == INIT) begin
                byte_cnt  <= '0;
                data_len  <= '0;
                drop_flag <= 1'b0;
            end else if (bus_idle) begin
                // truncated frame, a lone byte is treated as noise
                if (byte_cnt > byte_cnt_t'(1) && !drop_flag) begin
                    error <= 1'b1;
                    if (not_drop) begin
                        wr_flags <= sat_count(byte_cnt);
                        switch   <= 1'b1;
                    end
                end
                byte_cnt  <= '0;  // next frame counts from zero
                data_len  <= '0;
                drop_flag <= 1'b0;
            end else if (ser.strobe) begin
                wr_addr_q <= byte_cnt[7:0];
                wr_clk_q  <= !byte_cnt[8];  // page holds 256 bytes
                if (byte_cnt == 9'd0 && ser.data == filter && filter != BROADCAST_ADDR) begin
                    drop_flag <= 1'b1;  // own transmission
                end
                if (byte_cnt == 9'd1 && ser.data != filter && ser.data != BROADCAST_ADDR &&
                    filter != BROADCAST_ADDR) begin
                    drop_flag <= 1'b1;
                end
                if (byte_cnt == 9'd2) begin
                    data_len <= ser.data;
                end
                if (byte_cnt == last_idx && !drop_flag) begin
                    if (ser.crc == '0 || user_crc) begin  // zero residue over crc bytes
                        wr_flags <= '0;
                        switch   <= 1'b1;
                    end else begin
                        error <= 1'b1;
                        if (not_drop) begin
                            wr_flags <= sat_count(byte_cnt + 1'b1);
                            switch   <= 1'b1;
                        end
                    end
                end
                byte_cnt <= byte_cnt + 1'b1;
            end
            if (abort) begin
                error  <= 1'b0;
                switch <= 1'b0;
            end
        end
    end

endmodule

/* hw/rx_pp_ram.sv */
// ping-pong receive buffer
// two byte pages, write page select and page handover
// latched flags, pending page and host read port

`timescale 1ns/1ns

module rx_pp_ram (
    input  logic                   clk,
    input  logic                   reset_n,
    input  cd_frame_pkg::wr_port_t wr,
    input  cd_frame_pkg::flags_t   wr_flags,
    input  logic                   switch,
    input  cd_frame_pkg::buf_addr_t rd_addr,
    input  logic                   rd_done,
    output logic [7:0]             rd_byte,
    output cd_frame_pkg::flags_t   rd_flags,
    output logic                   rd_ready,
    output logic                   rx_lost
);
    import cd_frame_pkg::*;

    localparam int PAGE_BYTES = 2 ** $bits(buf_addr_t);

    logic [7:0] mem [2][PAGE_BYTES];
    logic       sel;      // page being written
    logic       pending;  // read page holds a frame
    logic       rd_free;

    assign rd_free  = !pending || rd_done;
    assign rd_ready = pending;

    always_ff @(posedge clk) begin
        if (wr.wr_clk) begin
            mem[sel][wr.wr_addr] <= wr.wr_byte;
        end
        rd_byte <= mem[~sel][rd_addr];
    end

    always_ff @(posedge clk) begin
        if (switch && rd_free) begin
            rd_flags <= wr_flags;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sel     <= 1'b0;
            pending <= 1'b0;
            rx_lost <= 1'b0;
        end else begin
            rx_lost <= 1'b0;
            if (rd_done) begin
                pending <= 1'b0;
            end
            if (switch) begin
                if (rd_free) begin
                    sel     <= ~sel;  // written page becomes the read page
                    pending <= 1'b1;
                end else begin
                    rx_lost <= 1'b1;  // host still busy, frame discarded
                end
            end
        end
    end

endmodule

/* hw/rx_ser.sv */
// serial deserializer
// start and stop bit checks, lsb-first shift register
// bitwise crc-16 update and wait-for-idle blocking

`timescale 1ns/1ns

module rx_ser (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  rx,
    input  logic                  sample_tick,
    input  logic                  force_wait_idle,
    input  logic                  bus_idle,
    output logic                  hunt,
    output cd_phy_pkg::ser_byte_t ser
);
    import cd_phy_pkg::*;

    typedef enum logic [1:0] {
        S_HUNT,
        S_DATA,
        S_STOP
    } ser_state_t;

    ser_state_t state;
    logic [2:0] bit_cnt;
    logic [7:0] shift_q;
    crc_t       crc_q;      // crc over the frame so far
    logic       wait_idle;  // start edges blocked until idle

    function automatic crc_t crc_step(crc_t crc_in, logic bit_in);
        crc_t crc_sh;
        crc_sh = crc_in >> 1;
        if (crc_in[0] ^ bit_in) begin
            crc_sh = crc_sh ^ CRC_POLY;
        end
        return crc_sh;
    endfunction

    assign hunt = (state == S_HUNT);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wait_idle <= 1'b0;
        end else if (bus_idle) begin
            wait_idle <= 1'b0;
        end else if (force_wait_idle) begin
            wait_idle <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (sample_tick && state == S_DATA) begin
            shift_q <= {rx, shift_q[7:1]};  // lsb arrives first
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= S_HUNT;
            bit_cnt <= '0;
            crc_q   <= CRC_INIT;
            ser     <= '0;
        end else begin
            ser.strobe <= 1'b0;
            if (bus_idle) begin
                crc_q <= CRC_INIT;  // new frame starts after idle
            end
            if (force_wait_idle) begin
                state <= S_HUNT;  // drop any byte in progress
            end else if (sample_tick) begin
                case (state)
                    S_HUNT: begin
                        if (!rx && !wait_idle) begin  // start bit still low at mid-bit
                            state   <= S_DATA;
                            bit_cnt <= '0;
                        end
                    end
                    S_DATA: begin
                        crc_q   <= crc_step(crc_q, rx);
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= S_STOP;
                        end
                    end
                    S_STOP: begin
                        state <= S_HUNT;
                        if (rx) begin  // low stop bit drops the byte
                            ser.data   <= shift_q;
                            ser.crc    <= crc_q;
                            ser.strobe <= 1'b1;
                        end
                    end
                    default: state <= S_HUNT;
                endcase
            end
        end
    end

endmodule

/* src.f */
+incdir+tests
hw/cd_frame_pkg.sv
hw/cd_phy_pkg.sv
hw/rx_bit_timer.sv
hw/rx_ser.sv
hw/rx_bytes.sv
hw/rx_pp_ram.sv
hw/cd_rx_top.sv
tests/tb_cd_rx.sv

/* tests/tb_cd_rx_util.svh */
// testbench helpers for the receive path
// galois lfsr, crc-16 model and frame builder
// serial bit, byte and frame drivers, value check

`ifndef TB_CD_RX_UTIL_SVH
`define TB_CD_RX_UTIL_SVH

logic [31:0] lfsr = 32'h5019e161;
logic [7:0]  frame[$];  // bytes of the frame under test

// one galois step, gives the bit shifted out
function automatic logic lfsr_bit();
    logic out_bit;
    out_bit = lfsr[0];
    lfsr = (lfsr >> 1) ^ (out_bit ? 32'h80200003 : 32'h0);
    return out_bit;
endfunction

function automatic logic [7:0] rand_bits(int n);
    logic [7:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
        val = {val[6:0], lfsr_bit()};
    end
    return val;
endfunction

// modbus crc, reflected polynomial, lsb first
function automatic logic [15:0] crc16_byte(logic [15:0] crc, logic [7:0] data);
    logic [15:0] c;
    c = crc ^ {8'h00, data};
    for (int i = 0; i < 8; i++) begin
        c = c[0] ? ((c >> 1) ^ 16'ha001) : (c >> 1);
    end
    return c;
endfunction

task automatic build_frame(logic [7:0] src, logic [7:0] dst, logic [7:0] len, logic bad_crc);
    logic [15:0] crc;
    frame.delete();
    frame.push_back(src);
    frame.push_back(dst);
    frame.push_back(len);
    for (int i = 0; i < len; i++) begin
        frame.push_back(rand_bits(8));
    end
    crc = 16'hffff;
    foreach (frame[i]) begin
        crc = crc16_byte(crc, frame[i]);
    end
    if (bad_crc) begin
        crc = crc ^ 16'h005a;  // a few flipped bits in the low byte
    end
    frame.push_back(crc[7:0]);
    frame.push_back(crc[15:8]);
endtask

task automatic send_bit(logic b);
    rx = b;
    repeat (BAUD) @(negedge clk);
endtask

task automatic send_byte(logic [7:0] data);
    send_bit(1'b0);  // start
    for (int i = 0; i < 8; i++) begin
        send_bit(data[i]);
    end
    send_bit(1'b1);  // stop
endtask

// frame[first] up to frame[last-1]
task automatic send_part(int first, int last);
    for (int i = first; i < last; i++) begin
        send_byte(frame[i]);
    end
endtask

task automatic idle_line();
    rx = 1'b1;
    repeat (12 * BAUD) @(negedge clk);
endtask

task automatic send_frame(int count);
    send_part(0, count);
    idle_line();
endtask

task automatic fail_run(string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1, "simulation stopped");
endtask

task automatic check_val(string name, logic [15:0] exp, logic [15:0] act);
    if (exp !== act) begin
        fail_run($sformatf("ERR %s expected %h got %h", name, exp, act));
    end
endtask

`endif

/* tests/tb_cd_rx.sv */
// testbench for the receive path
// clock, reset, DUT instance and pulse counters
// directed tests for filter, crc, truncation, abort and page handover

`timescale 1ns/1ns

module tb_cd_rx;
    import cd_phy_pkg::*;
    import cd_frame_pkg::*;

    localparam int    BAUD    = 8;
    localparam int    TIMEOUT = 4000;
    localparam addr_t NODE    = 8'h81;  // random sources stay below 8'h80

    logic      clk = 1'b0;
    logic      reset_n;
    logic      rx;
    div_t      baud_div;
    addr_t     filter;
    logic      user_crc;
    logic      not_drop;
    logic      abort;
    logic      error;
    buf_addr_t rd_addr;
    logic      rd_done;
    logic [7:0] rd_byte;
    flags_t    rd_flags;
    logic      rd_ready;
    logic      rx_lost;
    int        error_pulses = 0;
    int        lost_pulses = 0;
    logic      error_q = 1'b0;
    logic      lost_q = 1'b0;

    `include "tb_cd_rx_util.svh"

    always #10 clk = ~clk;

    cd_rx_top u_cd_rx_top (
        .clk      (clk),
        .reset_n  (reset_n),
        .rx       (rx),
        .baud_div (baud_div),
        .filter   (filter),
        .user_crc (user_crc),
        .not_drop (not_drop),
        .abort    (abort),
        .error    (error),
        .rd_addr  (rd_addr),
        .rd_done  (rd_done),
        .rd_byte  (rd_byte),
        .rd_flags (rd_flags),
        .rd_ready (rd_ready),
        .rx_lost  (rx_lost)
    );

    // rising edges of error and rx_lost
    always @(posedge clk) begin
        if (error && !error_q) begin
            error_pulses++;
        end
        if (rx_lost && !lost_q) begin
            lost_pulses++;
        end
        error_q = error;
        lost_q  = rx_lost;
    end

    task automatic wait_ready();
        int n;
        n = 0;
        while (!rd_ready) begin
            if (n == TIMEOUT) begin
                fail_run("timeout, rd_ready never rose");
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic wait_error(int target);
        int n;
        n = 0;
        while (error_pulses < target) begin
            if (n == TIMEOUT) begin
                fail_run("timeout, the expected error pulse did not come");
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic wait_lost(int target);
        int n;
        n = 0;
        while (lost_pulses < target) begin
            if (n == TIMEOUT) begin
                fail_run("timeout, rx_lost did not pulse");
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic expect_no_page(int exp_errors);
        for (int i = 0; i < 200; i++) begin
            @(negedge clk);
            check_val("rd_ready", 1'b0, rd_ready);
        end
        check_val("error pulses", exp_errors, error_pulses);
    endtask

    // reads nbytes of the page, then frees it
    task automatic read_page(flags_t exp_flags, int nbytes);
        wait_ready();
        check_val("rd_flags", exp_flags, rd_flags);
        for (int i = 0; i < nbytes; i++) begin
            rd_addr = buf_addr_t'(i);
            @(negedge clk);
            check_val($sformatf("rd_byte[%0d]", i), frame[i], rd_byte);
        end
        rd_done = 1'b1;
        @(negedge clk);
        rd_done = 1'b0;
        check_val("rd_ready", 1'b0, rd_ready);
    endtask

    task automatic good_frames();
        build_frame(rand_bits(7), NODE, rand_bits(4), 1'b0);
        send_frame(frame.size());
        read_page(8'h00, frame.size());
        build_frame(rand_bits(7), BROADCAST_ADDR, rand_bits(4), 1'b0);
        send_frame(frame.size());
        read_page(8'h00, frame.size());
    endtask

    task automatic bad_crc_frames();
        int base;
        base = error_pulses;
        build_frame(rand_bits(7), NODE, rand_bits(4), 1'b1);
        send_frame(frame.size());
        wait_error(base + 1);
        expect_no_page(base + 1);
        not_drop = 1'b1;  // keep the page, flags give len + 5
        build_frame(rand_bits(7), NODE, rand_bits(4), 1'b1);
        send_frame(frame.size());
        wait_error(base + 2);
        read_page(flags_t'(frame.size()), frame.size());
        not_drop = 1'b0;
    endtask

    task automatic address_filter();
        int base;
        base = error_pulses;
        build_frame(NODE, NODE, rand_bits(4), 1'b0);  // own source
        send_frame(frame.size());
        build_frame(rand_bits(7), rand_bits(7), rand_bits(4), 1'b0);
        send_frame(frame.size());
        expect_no_page(base);
        filter = BROADCAST_ADDR;
        build_frame(rand_bits(7), rand_bits(7), rand_bits(4), 1'b0);
        send_frame(frame.size());
        read_page(8'h00, frame.size());
        filter = NODE;
    endtask

    task automatic truncated_frames();
        int base;
        int k;
        base = error_pulses;
        k = 2 + rand_bits(2);
        build_frame(rand_bits(7), NODE, 4 + rand_bits(3), 1'b0);
        send_frame(k);
        wait_error(base + 1);
        expect_no_page(base + 1);
        not_drop = 1'b1;
        build_frame(rand_bits(7), NODE, 4 + rand_bits(3), 1'b0);
        send_frame(k);
        wait_error(base + 2);
        read_page(flags_t'(k), k);
        not_drop = 1'b0;
    endtask

    task automatic user_crc_and_abort();
        int base;
        base = error_pulses;
        user_crc = 1'b1;
        build_frame(rand_bits(7), NODE, rand_bits(4), 1'b1);
        send_frame(frame.size());
        read_page(8'h00, frame.size());
        user_crc = 1'b0;
        build_frame(rand_bits(7), NODE, 4 + rand_bits(3), 1'b0);
        send_part(0, 3);
        abort = 1'b1;
        @(negedge clk);
        abort = 1'b0;
        send_part(3, frame.size());
        idle_line();
        expect_no_page(base);
        build_frame(rand_bits(7), NODE, rand_bits(4), 1'b0);
        send_frame(frame.size());
        read_page(8'h00, frame.size());
        check_val("error pulses", base, error_pulses);
    endtask

    task automatic page_overrun();
        logic [7:0] first_frame[$];
        int         lost_base;
        lost_base = lost_pulses;
        check_val("rx_lost pulses", 16'd0, lost_base);  // every earlier page was freed
        build_frame(rand_bits(7), NODE, rand_bits(4), 1'b0);
        send_frame(frame.size());
        wait_ready();
        first_frame = frame;
        build_frame(rand_bits(7), NODE, rand_bits(4), 1'b0);  // page still held
        send_frame(frame.size());
        wait_lost(lost_base + 1);
        frame = first_frame;
        read_page(8'h00, frame.size());
        check_val("rx_lost pulses", lost_base + 1, lost_pulses);
        build_frame(rand_bits(7), BROADCAST_ADDR, rand_bits(4), 1'b0);
        send_frame(frame.size());
        read_page(8'h00, frame.size());
    endtask

    initial begin
        reset_n  = 1'b0;
        rx       = 1'b1;
        baud_div = div_t'(BAUD);
        filter   = NODE;
        user_crc = 1'b0;
        not_drop = 1'b0;
        abort    = 1'b0;
        rd_addr  = '0;
        rd_done  = 1'b0;
        repeat (10) @(negedge clk);
        reset_n = 1'b1;
        idle_line();  // the FSM resyncs on the first idle gap
        good_frames();
        bad_crc_frames();
        address_filter();
        truncated_frames();
        user_crc_and_abort();
        page_overrun();
        $display("No errors");
        $finish;
    end

endmodule
